// ==== include/rf_defines.svh ====
`ifndef RF_DEFINES_SVH
`define RF_DEFINES_SVH

// Register file geometry
`define RF_REGS 32
`define RF_ADDR_W 5

// Register width
`define RF_DATA_W 16

// Width of the arithmetic shift amount
`define RF_SHIFT_W 4

`endif

// ==== hdl/rf_pkg.sv ====
`include "rf_defines.svh"

package rf_pkg;

	typedef logic [`RF_DATA_W-1:0] data_t;
	typedef logic [`RF_ADDR_W-1:0] addr_t;
	typedef logic [`RF_SHIFT_W-1:0] shamt_t;

	typedef enum logic [2:0] {
		OP_WRITE = 3'd0,
		OP_READ = 3'd1,
		OP_READ2 = 3'd2,
		OP_MAX = 3'd3,
		OP_XOR = 3'd4,
		OP_SRA = 3'd5
	} op_e;

	// Command as it arrives on the input handshake
	typedef struct packed {
		op_e op;
		addr_t dest;
		addr_t src_a;
		addr_t src_b;
		shamt_t shamt;
		data_t imm;
	} cmd_t;

	// Command with its source operands already read
	typedef struct packed {
		op_e op;
		addr_t dest;
		shamt_t shamt;
		data_t imm;
		data_t val_a;
		data_t val_b;
	} issue_t;

	typedef struct packed {
		logic en;
		addr_t addr;
		data_t data;
	} wr_t;

	// aux only carries data for a two-register read
	typedef struct packed {
		op_e op;
		addr_t dest;
		data_t result;
		data_t aux;
	} resp_t;

	// Ops that store their result into dest
	function automatic logic writes_reg(op_e op);
		logic w;
		case (op)
			OP_WRITE,
			OP_MAX,
			OP_XOR,
			OP_SRA: begin
				w = 1'b1;
			end
			default: begin
				w = 1'b0;
			end
		endcase
		return w;
	endfunction

endpackage

// ==== hdl/reg_file.sv ====
`include "rf_defines.svh"

module reg_file (
	input logic clk,
	input logic reset,

	input rf_pkg::addr_t rd_addr_a,
	input rf_pkg::addr_t rd_addr_b,
	output rf_pkg::data_t rd_data_a,
	output rf_pkg::data_t rd_data_b,

	input rf_pkg::wr_t wr
);

	rf_pkg::data_t regs [`RF_REGS];

	// Single write port, all entries cleared on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `RF_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.en) begin
			regs[wr.addr] <= wr.data;
		end
	end

	// Asynchronous read ports
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

endmodule

// ==== hdl/operand_fetch.sv ====
module operand_fetch (
	input rf_pkg::cmd_t cmd,

	output rf_pkg::addr_t rd_addr_a,
	output rf_pkg::addr_t rd_addr_b,
	input rf_pkg::data_t rd_data_a,
	input rf_pkg::data_t rd_data_b,

	// Write that lands on the coming edge
	input rf_pkg::wr_t wr,

	output rf_pkg::issue_t issue
);

	logic hit_a;
	logic hit_b;

	assign rd_addr_a = cmd.src_a;
	assign rd_addr_b = cmd.src_b;

	// Register file still holds the old value this cycle
	assign hit_a = wr.en && (wr.addr == cmd.src_a);
	assign hit_b = wr.en && (wr.addr == cmd.src_b);

	always_comb begin
		issue.op = cmd.op;
		issue.dest = cmd.dest;
		issue.shamt = cmd.shamt;
		issue.imm = cmd.imm;

		if (hit_a) begin
			issue.val_a = wr.data;
		end else begin
			issue.val_a = rd_data_a;
		end

		if (hit_b) begin
			issue.val_b = wr.data;
		end else begin
			issue.val_b = rd_data_b;
		end
	end

endmodule

// ==== hdl/pipe_reg.sv ====
module pipe_reg #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic reset,

	input logic in_valid,
	output logic in_ready,
	input payload_t in_data,

	output logic out_valid,
	input logic out_ready,
	output payload_t out_data
);

	logic valid_q;
	payload_t data_q;
	logic accept;

	// Free slot, or the held item leaves this cycle
	assign in_ready = !valid_q || out_ready;
	assign accept = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else if (in_ready) begin
			valid_q <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			data_q <= in_data;
		end
	end

	assign out_valid = valid_q;
	assign out_data = data_q;

endmodule

// ==== hdl/execute_stage.sv ====
module execute_stage (
	input rf_pkg::issue_t issue,

	// Item moves from the issue register into the response register
	input logic commit,

	output rf_pkg::resp_t resp,
	output rf_pkg::wr_t wr
);

	rf_pkg::data_t result;
	rf_pkg::data_t aux;
	rf_pkg::data_t max_val;
	rf_pkg::data_t sra_val;

	// Unsigned compare
	assign max_val = (issue.val_a > issue.val_b) ? issue.val_a : issue.val_b;

	// Sign bit of val_a fills from the top
	assign sra_val = rf_pkg::data_t'($signed(issue.val_a) >>> issue.shamt);

	always_comb begin
		aux = '0;
		case (issue.op)
			rf_pkg::OP_WRITE: begin
				result = issue.imm;
			end
			rf_pkg::OP_READ: begin
				result = issue.val_a;
			end
			rf_pkg::OP_READ2: begin
				result = issue.val_a;
				aux = issue.val_b;
			end
			rf_pkg::OP_MAX: begin
				result = max_val;
			end
			rf_pkg::OP_XOR: begin
				result = issue.val_a ^ issue.val_b;
			end
			rf_pkg::OP_SRA: begin
				result = sra_val;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	always_comb begin
		resp.op = issue.op;
		resp.dest = issue.dest;
		resp.result = result;
		resp.aux = aux;
	end

	// One write per item, on the cycle it commits
	always_comb begin
		wr.en = commit && rf_pkg::writes_reg(issue.op);
		wr.addr = issue.dest;
		wr.data = result;
	end

endmodule

// ==== hdl/rf_proc_top.sv ====
module rf_proc_top (
	input logic clk,
	input logic reset,

	input logic cmd_valid,
	output logic cmd_ready,
	input rf_pkg::cmd_t cmd,

	output logic resp_valid,
	input logic resp_ready,
	output rf_pkg::resp_t resp
);

	rf_pkg::addr_t rd_addr_a;
	rf_pkg::addr_t rd_addr_b;
	rf_pkg::data_t rd_data_a;
	rf_pkg::data_t rd_data_b;
	rf_pkg::wr_t wr;

	rf_pkg::issue_t fetch_issue;
	rf_pkg::issue_t exec_issue;
	logic issue_valid;

	rf_pkg::resp_t exec_resp;
	logic resp_in_ready;
	logic commit;

	reg_file reg_file_inst (
		.clk(clk),
		.reset(reset),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.wr(wr)
	);

	// Stage 1 operand fetch
	operand_fetch operand_fetch_inst (
		.cmd(cmd),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.wr(wr),
		.issue(fetch_issue)
	);

	pipe_reg #(
		.payload_t(rf_pkg::issue_t)
	) issue_reg_inst (
		.clk(clk),
		.reset(reset),
		.in_valid(cmd_valid),
		.in_ready(cmd_ready),
		.in_data(fetch_issue),
		.out_valid(issue_valid),
		.out_ready(resp_in_ready),
		.out_data(exec_issue)
	);

	// Stage 2 execute
	assign commit = issue_valid && resp_in_ready;

	execute_stage execute_stage_inst (
		.issue(exec_issue),
		.commit(commit),
		.resp(exec_resp),
		.wr(wr)
	);

	// Stage 3 response
	pipe_reg #(
		.payload_t(rf_pkg::resp_t)
	) resp_reg_inst (
		.clk(clk),
		.reset(reset),
		.in_valid(issue_valid),
		.in_ready(resp_in_ready),
		.in_data(exec_resp),
		.out_valid(resp_valid),
		.out_ready(resp_ready),
		.out_data(resp)
	);

endmodule

// ==== verif/rf_proc_sva.sv ====
module rf_proc_sva (
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	input logic cmd_ready,
	input rf_pkg::cmd_t cmd,
	input logic resp_valid,
	input logic resp_ready,
	input rf_pkg::resp_t resp
);

	int fail_count = 0;

	// A stalled command stays on the bus unchanged
	cmd_hold: assert property (@(posedge clk) disable iff (reset)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
	else begin
		$error("cmd dropped or changed while cmd_ready was low");
		fail_count++;
	end

	resp_hold: assert property (@(posedge clk) disable iff (reset)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp))
	else begin
		$error("resp dropped or changed while resp_ready was low");
		fail_count++;
	end

	// Pipeline comes out of reset empty
	resp_idle_in_reset: assert property (@(posedge clk) reset |=> !resp_valid)
	else begin
		$error("resp_valid high right after a reset cycle");
		fail_count++;
	end

	cmd_ready_after_reset: assert property (@(posedge clk) reset |=> cmd_ready)
	else begin
		$error("cmd_ready low right after a reset cycle");
		fail_count++;
	end

endmodule

// ==== verif/rf_proc_checker.sv ====
`include "rf_defines.svh"

module rf_proc_checker (
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	input logic cmd_ready,
	input rf_pkg::cmd_t cmd,
	input logic resp_valid,
	input logic resp_ready,
	input rf_pkg::resp_t resp,
	output int error_count,
	output int resp_count
);

	rf_pkg::data_t model_regs [`RF_REGS];
	rf_pkg::resp_t expected_q [$];
	int accept_cycle_q [$];
	int cycle;
	int last_stall_cycle;

	// Sign bit shifted in one position at a time
	function automatic rf_pkg::data_t shift_right_signed(rf_pkg::data_t value,
			rf_pkg::shamt_t amount);
		rf_pkg::data_t v;
		v = value;
		for (int i = 0; i < int'(amount); i++) begin
			v = {v[`RF_DATA_W-1], v[`RF_DATA_W-1:1]};
		end
		return v;
	endfunction

	task automatic compare_value(string name, logic [15:0] expected, logic [15:0] actual);
		if (expected !== actual) begin
			$display("error %s: expected %h, got %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_latency(int accepted_at);
		int latency;
		latency = cycle - accepted_at;
		if (latency < 2) begin
			$display("Response came %0d cycles after its command, too soon", latency);
			error_count++;
		end else if (last_stall_cycle <= accepted_at && latency != 2) begin
			$display("Response came %0d cycles after its command with resp_ready high",
				latency);
			error_count++;
		end
	endtask

	always @(posedge clk) begin
		rf_pkg::resp_t expected;
		rf_pkg::data_t a;
		rf_pkg::data_t b;
		logic stores;
		int accepted_at;
		if (reset) begin
			for (int i = 0; i < `RF_REGS; i++) begin
				model_regs[i] = '0;
			end
			expected_q.delete();
			accept_cycle_q.delete();
			cycle = 0;
			last_stall_cycle = 0;
			error_count = 0;
			resp_count = 0;
		end else begin
			cycle = cycle + 1;
			if (resp_valid && resp_ready) begin
				resp_count = resp_count + 1;
				if (expected_q.size() == 0) begin
					$display("Response at cycle %0d had no command waiting for it", cycle);
					error_count++;
				end else begin
					expected = expected_q.pop_front();
					accepted_at = accept_cycle_q.pop_front();
					compare_value("resp.op", 16'(expected.op), 16'(resp.op));
					compare_value("resp.dest", 16'(expected.dest), 16'(resp.dest));
					compare_value("resp.result", expected.result, resp.result);
					compare_value("resp.aux", expected.aux, resp.aux);
					check_latency(accepted_at);
				end
			end
			if (!resp_ready) begin
				last_stall_cycle = cycle;
			end

			// Model executes each command in acceptance order
			if (cmd_valid && cmd_ready) begin
				a = model_regs[cmd.src_a];
				b = model_regs[cmd.src_b];
				expected.op = cmd.op;
				expected.dest = cmd.dest;
				expected.aux = '0;
				stores = 1'b1;
				case (cmd.op)
					rf_pkg::OP_WRITE: expected.result = cmd.imm;
					rf_pkg::OP_READ: begin
						expected.result = a;
						stores = 1'b0;
					end
					rf_pkg::OP_READ2: begin
						expected.result = a;
						expected.aux = b;
						stores = 1'b0;
					end
					rf_pkg::OP_MAX: expected.result = (b > a) ? b : a;
					rf_pkg::OP_XOR: expected.result = a ^ b;
					rf_pkg::OP_SRA: expected.result = shift_right_signed(a, cmd.shamt);
					default: begin
						$display("Command with an unknown opcode was accepted");
						error_count++;
						expected.result = '0;
						stores = 1'b0;
					end
				endcase
				if (stores) begin
					model_regs[cmd.dest] = expected.result;
				end
				expected_q.push_back(expected);
				accept_cycle_q.push_back(cycle);
			end
		end
	end

endmodule

// ==== verif/rf_proc_tb.sv ====
`include "rf_defines.svh"

module rf_proc_tb;

	localparam int N_CMDS = 400;
	localparam int TIMEOUT_CYCLES = N_CMDS * 4 + 50;

	logic clk;
	logic reset;
	logic cmd_valid;
	logic cmd_ready;
	rf_pkg::cmd_t cmd;
	logic resp_valid;
	logic resp_ready;
	rf_pkg::resp_t resp;

	int error_count;
	int resp_count;
	int cycles = 0;
	logic cmd_taken = 1'b0;
	logic [31:0] lcg_state = 32'd74;
	rf_pkg::cmd_t directed_q [$];

	rf_proc_top rf_proc_top_inst (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd(cmd),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.resp(resp)
	);

	rf_proc_checker rf_proc_checker_inst (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd(cmd),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.resp(resp),
		.error_count(error_count),
		.resp_count(resp_count)
	);

	bind rf_proc_top rf_proc_sva rf_proc_sva_inst (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd(cmd),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.resp(resp)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		cmd_taken <= !reset && cmd_valid && cmd_ready;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {16'd0, lcg_state[31:16]};
	endfunction

	// Mostly the low eight registers so reads hit recent writes
	function automatic rf_pkg::addr_t random_addr();
		logic [31:0] r;
		r = next_random();
		if (r[3:0] < 4'd12) begin
			return {2'b00, r[10:8]};
		end
		return r[12:8];
	endfunction

	function automatic rf_pkg::cmd_t random_cmd();
		rf_pkg::cmd_t c;
		c.op = rf_pkg::op_e'(3'(next_random() % 32'd6));
		c.dest = random_addr();
		c.src_a = random_addr();
		c.src_b = random_addr();
		c.shamt = rf_pkg::shamt_t'(next_random());
		c.imm = rf_pkg::data_t'(next_random());
		return c;
	endfunction

	function automatic rf_pkg::cmd_t make_cmd(rf_pkg::op_e op, rf_pkg::addr_t dest,
			rf_pkg::addr_t src_a, rf_pkg::addr_t src_b, rf_pkg::shamt_t shamt,
			rf_pkg::data_t imm);
		rf_pkg::cmd_t c;
		c.op = op;
		c.dest = dest;
		c.src_a = src_a;
		c.src_b = src_b;
		c.shamt = shamt;
		c.imm = imm;
		return c;
	endfunction

	initial begin
		int issued;
		int failures;
		issued = 0;
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		resp_ready = 1'b0;

		// Directed opening, then dependent pairs back to back
		directed_q.push_back(make_cmd(rf_pkg::OP_WRITE, 5'd1, 5'd0, 5'd0, 4'd0, 16'h8a5c));
		directed_q.push_back(make_cmd(rf_pkg::OP_READ, 5'd0, 5'd1, 5'd0, 4'd0, 16'h0));
		directed_q.push_back(make_cmd(rf_pkg::OP_READ, 5'd0, 5'd2, 5'd0, 4'd0, 16'h0));
		directed_q.push_back(make_cmd(rf_pkg::OP_WRITE, 5'd2, 5'd0, 5'd0, 4'd0, 16'h1234));
		directed_q.push_back(make_cmd(rf_pkg::OP_READ2, 5'd0, 5'd1, 5'd2, 4'd0, 16'h0));
		directed_q.push_back(make_cmd(rf_pkg::OP_MAX, 5'd3, 5'd1, 5'd2, 4'd0, 16'h0));
		directed_q.push_back(make_cmd(rf_pkg::OP_XOR, 5'd4, 5'd1, 5'd2, 4'd0, 16'h0));
		directed_q.push_back(make_cmd(rf_pkg::OP_SRA, 5'd5, 5'd1, 5'd0, 4'd4, 16'h0));
		directed_q.push_back(make_cmd(rf_pkg::OP_READ2, 5'd0, 5'd3, 5'd4, 4'd0, 16'h0));
		directed_q.push_back(make_cmd(rf_pkg::OP_WRITE, 5'd6, 5'd0, 5'd0, 4'd0, 16'h00ff));
		directed_q.push_back(make_cmd(rf_pkg::OP_XOR, 5'd6, 5'd6, 5'd1, 4'd0, 16'h0));
		directed_q.push_back(make_cmd(rf_pkg::OP_READ, 5'd0, 5'd6, 5'd0, 4'd0, 16'h0));
		directed_q.push_back(make_cmd(rf_pkg::OP_READ2, 5'd0, 5'd5, 5'd6, 4'd0, 16'h0));

		repeat (3) @(negedge clk);
		reset = 1'b0;

		while (resp_count < N_CMDS && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			if (cmd_taken) begin
				cmd_valid = 1'b0;
			end
			if (!cmd_valid && issued < N_CMDS) begin
				if (issued < directed_q.size()) begin
					cmd = directed_q[issued];
					cmd_valid = 1'b1;
					issued++;
				end else if (next_random() % 32'd4 != 32'd0) begin
					cmd = random_cmd();
					cmd_valid = 1'b1;
					issued++;
				end
			end
			if (issued <= directed_q.size()) begin
				resp_ready = 1'b1;
			end else begin
				resp_ready = next_random() % 32'd4 != 32'd0;
			end
		end

		// Idle cycles expose any extra response
		@(negedge clk);
		cmd_valid = 1'b0;
		resp_ready = 1'b1;
		repeat (6) @(negedge clk);

		failures = error_count + rf_proc_top_inst.rf_proc_sva_inst.fail_count;
		if (resp_count < N_CMDS) begin
			$display("Timeout after %0d cycles with %0d of %0d responses received",
				cycles, resp_count, N_CMDS);
			failures++;
		end
		$display("Summary: %0d commands, %0d responses, %0d errors",
			N_CMDS, resp_count, failures);
		if (failures == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+include
hdl/rf_pkg.sv
hdl/reg_file.sv
hdl/operand_fetch.sv
hdl/pipe_reg.sv
hdl/execute_stage.sv
hdl/rf_proc_top.sv
verif/rf_proc_sva.sv
verif/rf_proc_checker.sv
verif/rf_proc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= rf_proc_tb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/rf_defines.svh
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -qx "No errors" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
